/* hw/rx_flit_pkg.sv */
`default_nettype none

package rx_flit_pkg;

    // ============================================================
    // Widths and codes
    // ============================================================
    localparam int FLIT_W = 128;
    localparam int CRC_W  = 32;

    // CRC-32 generator, zero start, MSB first, no reflection or final xor
    localparam logic [CRC_W-1:0] CRC_POLY = 32'h741B_8CD7;

    // Flow commands, anything else is a normal request or response
    localparam logic [5:0] CMD_PRET  = 6'h01;
    localparam logic [5:0] CMD_TRET  = 6'h02;
    localparam logic [5:0] CMD_IRTRY = 6'h03;

    // ============================================================
    // Header fields
    // ============================================================
    function automatic logic [5:0] f_cmd(input logic [FLIT_W-1:0] flit);
        return flit[5:0];
    endfunction

    function automatic logic [3:0] f_lng(input logic [FLIT_W-1:0] flit);
        return flit[10:7];
    endfunction

    function automatic logic [8:0] f_tag(input logic [FLIT_W-1:0] flit);
        return flit[23:15];
    endfunction

    function automatic logic [33:0] f_adrs(input logic [FLIT_W-1:0] flit);
        return flit[57:24];
    endfunction

    // ============================================================
    // Tail fields
    // ============================================================
    function automatic logic [7:0] f_rrp(input logic [FLIT_W-1:0] flit);
        return flit[71:64];
    endfunction

    function automatic logic [7:0] f_frp(input logic [FLIT_W-1:0] flit);
        return flit[79:72];
    endfunction

    function automatic logic [2:0] f_seq(input logic [FLIT_W-1:0] flit);
        return flit[82:80];
    endfunction

    function automatic logic [2:0] f_rtc(input logic [FLIT_W-1:0] flit);
        return flit[90:88];
    endfunction

    function automatic logic [CRC_W-1:0] f_crc(input logic [FLIT_W-1:0] flit);
        return flit[127:96];
    endfunction

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic f_is_flow(input logic [5:0] cmd);
        return (cmd == CMD_PRET) || (cmd == CMD_TRET) || (cmd == CMD_IRTRY);
    endfunction

    // Folds one flit into the running remainder, bit 127 first
    function automatic logic [CRC_W-1:0] f_crc_flit(
        input logic [CRC_W-1:0]  crc_in,
        input logic [FLIT_W-1:0] flit
    );
        logic [CRC_W-1:0] rem;
        logic             fb;
        rem = crc_in;
        for (int i = FLIT_W - 1; i >= 0; i--) begin
            fb  = rem[CRC_W-1] ^ flit[i];
            rem = {rem[CRC_W-2:0], 1'b0};
            if (fb) begin
                rem = rem ^ CRC_POLY;
            end
        end
        return rem;
    endfunction

endpackage

`default_nettype wire

/* hw/rx_crc_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_crc_accum (
    input  wire logic                           clk,
    input  wire logic                           res_n,
    input  wire logic                           i_valid,
    input  wire logic                           i_hdr,
    input  wire logic                           i_tail,
    input  wire logic [rx_flit_pkg::FLIT_W-1:0] i_data,
    output logic                                o_crc_ok,
    output logic                                o_crc_poison,
    output logic                                o_crc_err
);

    import rx_flit_pkg::*;

    // ============================================================
    // Remainder update
    // ============================================================
    logic [CRC_W-1:0]  crc_run;
    logic [CRC_W-1:0]  crc_base;
    logic [CRC_W-1:0]  crc_next;
    logic [CRC_W-1:0]  crc_rx;
    logic [FLIT_W-1:0] flit_in;
    logic              tail_v;

    assign tail_v = i_valid & i_tail;

    // The received CRC field is zero while it is folded in
    always_comb begin
        flit_in = i_data;
        if (i_tail) begin
            flit_in[127:96] = '0;
        end
    end

    // A header restarts the packet from a zero remainder
    assign crc_base = i_hdr ? '0 : crc_run;
    assign crc_next = f_crc_flit(crc_base, flit_in);
    assign crc_rx   = f_crc(i_data);

    always_ff @(posedge clk or negedge res_n) begin
        if (!res_n) begin
            crc_run <= '0;
        end else if (i_valid) begin
            crc_run <= crc_next;
        end
    end

    // ============================================================
    // Tail verdict
    // ============================================================
    logic match;
    logic inv_match;

    assign match     = (crc_next == crc_rx);
    assign inv_match = (crc_next == ~crc_rx);

    // One of the three pulses for one cycle after every tail
    always_ff @(posedge clk or negedge res_n) begin
        if (!res_n) begin
            o_crc_ok     <= 1'b0;
            o_crc_poison <= 1'b0;
            o_crc_err    <= 1'b0;
        end else begin
            o_crc_ok     <= tail_v & match;
            o_crc_poison <= tail_v & inv_match;
            o_crc_err    <= tail_v & ~match & ~inv_match;
        end
    end

endmodule

`default_nettype wire

/* hw/rx_field_check.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_field_check #(
    parameter int MAX_LNG = 9
) (
    input  wire logic                           clk,
    input  wire logic                           res_n,
    input  wire logic                           i_valid,
    input  wire logic                           i_hdr,
    input  wire logic                           i_tail,
    input  wire logic [rx_flit_pkg::FLIT_W-1:0] i_data,
    output logic                                o_fld_err,
    output logic                                o_rtc_ok,
    output logic                                o_is_flow
);

    import rx_flit_pkg::*;

    // ============================================================
    // Packet state
    // ============================================================
    logic       in_pkt;
    logic [5:0] cmd_q;
    logic [3:0] lng_q;
    logic [4:0] cnt_q;
    logic       seq_err_q;

    // Current packet view, with the header taking effect on its own flit
    logic [5:0] cur_cmd;
    logic [3:0] cur_lng;
    logic [4:0] cur_cnt;
    logic       single;
    logic       nested;

    assign cur_cmd = i_hdr ? f_cmd(i_data) : cmd_q;
    assign cur_lng = i_hdr ? f_lng(i_data) : lng_q;
    assign single  = i_hdr & i_tail;
    assign nested  = i_hdr & in_pkt;

    // Count saturates so an overlong packet still mismatches
    always_comb begin
        if (i_hdr) begin
            cur_cnt = 5'd1;
        end else if (cnt_q == 5'h1f) begin
            cur_cnt = cnt_q;
        end else begin
            cur_cnt = cnt_q + 5'd1;
        end
    end

    // ============================================================
    // Checks at the tail
    // ============================================================
    logic lng_bad;
    logic cnt_bad;
    logic orphan;
    logic flow_err;
    logic is_flow;

    assign lng_bad = (cur_lng == 4'd0) || (cur_lng > 4'(MAX_LNG));
    assign cnt_bad = (cur_cnt != {1'b0, cur_lng});
    assign orphan  = ~i_hdr & ~in_pkt;
    assign is_flow = f_is_flow(cur_cmd);

    // Zero-field rules apply to single-flit flow packets only
    always_comb begin
        flow_err = 1'b0;
        if (single && is_flow) begin
            if (|f_tag(i_data) || |f_adrs(i_data)) begin
                flow_err = 1'b1;
            end
            if ((cur_cmd != CMD_TRET) && (|f_rtc(i_data) || |f_seq(i_data))) begin
                flow_err = 1'b1;
            end
            if ((cur_cmd == CMD_PRET) && |f_frp(i_data)) begin
                flow_err = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge res_n) begin
        if (!res_n) begin
            in_pkt    <= 1'b0;
            cmd_q     <= '0;
            lng_q     <= '0;
            cnt_q     <= '0;
            seq_err_q <= 1'b0;
            o_fld_err <= 1'b0;
            o_rtc_ok  <= 1'b0;
            o_is_flow <= 1'b0;
        end else begin
            o_fld_err <= 1'b0;
            o_rtc_ok  <= 1'b0;
            o_is_flow <= 1'b0;
            if (i_valid && i_tail) begin
                in_pkt    <= 1'b0;
                seq_err_q <= 1'b0;
                o_fld_err <= lng_bad | cnt_bad | orphan | nested | seq_err_q | flow_err;
                o_rtc_ok  <= ~single | (cur_cmd == CMD_TRET) | ~is_flow;
                o_is_flow <= is_flow;
            end else if (i_valid) begin
                if (i_hdr) begin
                    // A second header restarts capture and marks the packet bad
                    in_pkt    <= 1'b1;
                    cmd_q     <= cur_cmd;
                    lng_q     <= cur_lng;
                    seq_err_q <= nested;
                end
                cnt_q <= cur_cnt;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/rx_flit_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_flit_merge (
    input  wire logic                           clk,
    input  wire logic                           res_n,
    input  wire logic                           i_valid,
    input  wire logic                           i_hdr,
    input  wire logic                           i_tail,
    input  wire logic [rx_flit_pkg::FLIT_W-1:0] i_data,
    input  wire logic                           i_crc_ok,
    input  wire logic                           i_crc_poison,
    input  wire logic                           i_crc_err,
    input  wire logic                           i_fld_err,
    input  wire logic                           i_rtc_ok,
    input  wire logic                           i_is_flow,
    output logic                                o_valid,
    output logic                                o_hdr,
    output logic                                o_tail,
    output logic [rx_flit_pkg::FLIT_W-1:0]      o_data,
    output logic                                o_error,
    output logic                                o_poisoned,
    output logic                                o_rtc,
    output logic                                o_flow
);

    import rx_flit_pkg::*;

    // ============================================================
    // Stream delay, lines up with the checker verdicts
    // ============================================================
    logic              v_d;
    logic              h_d;
    logic              t_d;
    logic [FLIT_W-1:0] data_d;
    logic              tail_chk;

    always_ff @(posedge clk or negedge res_n) begin
        if (!res_n) begin
            v_d <= 1'b0;
            h_d <= 1'b0;
            t_d <= 1'b0;
        end else begin
            v_d <= i_valid;
            h_d <= i_valid & i_hdr;
            t_d <= i_valid & i_tail;
        end
    end

    always_ff @(posedge clk) begin
        data_d <= i_data;
    end

    // Flags only on a tail that has a CRC verdict
    assign tail_chk = t_d & (i_crc_ok | i_crc_poison | i_crc_err);

    // ============================================================
    // Output register
    // ============================================================
    always_ff @(posedge clk or negedge res_n) begin
        if (!res_n) begin
            o_valid    <= 1'b0;
            o_hdr      <= 1'b0;
            o_tail     <= 1'b0;
            o_error    <= 1'b0;
            o_poisoned <= 1'b0;
            o_rtc      <= 1'b0;
            o_flow     <= 1'b0;
        end else begin
            o_valid    <= v_d;
            o_hdr      <= h_d;
            o_tail     <= t_d;
            o_error    <= tail_chk & (i_crc_err | i_fld_err);
            o_poisoned <= tail_chk & i_crc_poison;
            o_rtc      <= tail_chk & i_rtc_ok;
            o_flow     <= tail_chk & i_is_flow;
        end
    end

    always_ff @(posedge clk) begin
        o_data <= data_d;
    end

endmodule

`default_nettype wire

/* hw/rx_crc_check_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_crc_check_top #(
    parameter int MAX_LNG = 9
) (
    input  wire logic                           clk,
    input  wire logic                           res_n,
    input  wire logic                           i_valid,
    input  wire logic                           i_hdr,
    input  wire logic                           i_tail,
    input  wire logic [rx_flit_pkg::FLIT_W-1:0] i_data,
    output logic                                o_valid,
    output logic                                o_hdr,
    output logic                                o_tail,
    output logic [rx_flit_pkg::FLIT_W-1:0]      o_data,
    output logic                                o_error,
    output logic                                o_poisoned,
    output logic                                o_rtc,
    output logic                                o_flow
);

    // CRC verdict
    logic crc_ok;
    logic crc_poison;
    logic crc_err;

    // Field verdict
    logic fld_err;
    logic rtc_ok;
    logic is_flow;

    rx_crc_accum u_crc_accum (
        .clk          (clk),
        .res_n        (res_n),
        .i_valid      (i_valid),
        .i_hdr        (i_hdr),
        .i_tail       (i_tail),
        .i_data       (i_data),
        .o_crc_ok     (crc_ok),
        .o_crc_poison (crc_poison),
        .o_crc_err    (crc_err)
    );

    rx_field_check #(
        .MAX_LNG (MAX_LNG)
    ) u_field_check (
        .clk       (clk),
        .res_n     (res_n),
        .i_valid   (i_valid),
        .i_hdr     (i_hdr),
        .i_tail    (i_tail),
        .i_data    (i_data),
        .o_fld_err (fld_err),
        .o_rtc_ok  (rtc_ok),
        .o_is_flow (is_flow)
    );

    rx_flit_merge u_flit_merge (
        .clk          (clk),
        .res_n        (res_n),
        .i_valid      (i_valid),
        .i_hdr        (i_hdr),
        .i_tail       (i_tail),
        .i_data       (i_data),
        .i_crc_ok     (crc_ok),
        .i_crc_poison (crc_poison),
        .i_crc_err    (crc_err),
        .i_fld_err    (fld_err),
        .i_rtc_ok     (rtc_ok),
        .i_is_flow    (is_flow),
        .o_valid      (o_valid),
        .o_hdr        (o_hdr),
        .o_tail       (o_tail),
        .o_data       (o_data),
        .o_error      (o_error),
        .o_poisoned   (o_poisoned),
        .o_rtc        (o_rtc),
        .o_flow       (o_flow)
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_res_n
);

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;
    end

    // Reset held low for five rising edges, released on a falling edge
    initial begin
        o_res_n = 1'b0;
        repeat (5) @(posedge o_clk);
        @(negedge o_clk);
        o_res_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/rx_crc_check_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_crc_check_sva (
    input wire logic clk,
    input wire logic res_n,
    input wire logic i_out_valid,
    input wire logic i_out_hdr,
    input wire logic i_out_tail,
    input wire logic i_out_error,
    input wire logic i_out_poisoned,
    input wire logic i_out_rtc,
    input wire logic i_out_flow,
    input wire logic i_fld_err
);

    a_marker_valid: assert property (@(posedge clk) disable iff (!res_n)
        (i_out_hdr || i_out_tail) |-> i_out_valid)
        else $error("header or tail marker without valid");

    a_flag_tail: assert property (@(posedge clk) disable iff (!res_n)
        (i_out_error || i_out_poisoned || i_out_rtc || i_out_flow) |-> i_out_tail)
        else $error("packet flag on a flit that is not a tail");

    // Error beside poisoned must come from the field checker one cycle earlier
    a_poison_no_crc_err: assert property (@(posedge clk) disable iff (!res_n)
        (i_out_error && i_out_poisoned) |-> $past(i_fld_err))
        else $error("CRC alone set both poisoned and error");

    a_reset_quiet: assert property (@(posedge clk)
        !res_n |-> !(i_out_valid || i_out_hdr || i_out_tail || i_out_error
                     || i_out_poisoned || i_out_rtc || i_out_flow))
        else $error("output active during reset");

endmodule

bind rx_crc_check_top rx_crc_check_sva u_sva (
    .clk            (clk),
    .res_n          (res_n),
    .i_out_valid    (o_valid),
    .i_out_hdr      (o_hdr),
    .i_out_tail     (o_tail),
    .i_out_error    (o_error),
    .i_out_poisoned (o_poisoned),
    .i_out_rtc      (o_rtc),
    .i_out_flow     (o_flow),
    .i_fld_err      (fld_err)
);

`default_nettype wire

/* tests/tb_rx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rx_checker (
    input wire logic                           clk,
    input wire logic                           res_n,
    input wire logic                           i_valid,
    input wire logic                           i_hdr,
    input wire logic                           i_tail,
    input wire logic [rx_flit_pkg::FLIT_W-1:0] i_data,
    input wire logic                           o_valid,
    input wire logic                           o_hdr,
    input wire logic                           o_tail,
    input wire logic [rx_flit_pkg::FLIT_W-1:0] o_data,
    input wire logic                           o_error,
    input wire logic                           o_poisoned,
    input wire logic                           o_rtc,
    input wire logic                           o_flow
);

    import rx_flit_pkg::*;

    // Input flits seen on the DUT side, with the cycle they were sampled
    logic [FLIT_W-1:0] q_data[$];
    logic              q_hdr[$];
    logic              q_tail[$];
    int                q_cyc[$];

    // Expected per-packet results
    string q_name[$];
    logic  q_err[$];
    logic  q_pois[$];
    logic  q_rtc[$];
    logic  q_flow[$];
    int    q_len[$];

    int    mismatches = 0;
    int    other_errs = 0;
    int    flits_seen = 0;
    int    pkts_seen  = 0;
    int    cyc        = 0;
    int    pkt_flits  = 0;
    int    lat;
    string cur;

    task automatic expect_packet(input string name, input logic err, input logic pois,
                                 input logic rtc, input logic flow, input int len);
        q_name.push_back(name);
        q_err.push_back(err);
        q_pois.push_back(pois);
        q_rtc.push_back(rtc);
        q_flow.push_back(flow);
        q_len.push_back(len);
    endtask

    function automatic bit drained();
        return (q_data.size() == 0) && (q_name.size() == 0);
    endfunction

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %s %s expected %0b actual %0b", name, what, exp, act);
        end
    endtask

    // Outputs read here hold the values from before this edge's update
    always @(posedge clk) begin
        if (res_n) begin
            cyc++;
            if (i_valid) begin
                q_data.push_back(i_data);
                q_hdr.push_back(i_hdr);
                q_tail.push_back(i_tail);
                q_cyc.push_back(cyc);
            end
            cur = (q_name.size() > 0) ? q_name[0] : "none";
            if (o_valid) begin
                if (q_data.size() == 0) begin
                    other_errs++;
                    $display("Output flit appeared with no input flit behind it");
                end else begin
                    flits_seen++;
                    pkt_flits++;
                    lat = cyc - q_cyc[0];
                    if (lat != 2) begin
                        mismatches++;
                        $display("Mismatch %s latency expected 2 actual %0d", cur, lat);
                    end
                    if (q_data[0] !== o_data) begin
                        mismatches++;
                        $display("Mismatch %s data expected %h actual %h",
                                 cur, q_data[0], o_data);
                    end
                    check_bit(cur, "hdr", q_hdr[0], o_hdr);
                    check_bit(cur, "tail", q_tail[0], o_tail);
                    void'(q_data.pop_front());
                    void'(q_hdr.pop_front());
                    void'(q_tail.pop_front());
                    void'(q_cyc.pop_front());
                end
                if (!o_tail && (o_error || o_poisoned || o_rtc || o_flow)) begin
                    other_errs++;
                    $display("Packet flag set on a flit that is not a tail in %s", cur);
                end
                if (o_tail && q_name.size() > 0) begin
                    pkts_seen++;
                    check_bit(cur, "error", q_err[0], o_error);
                    check_bit(cur, "poisoned", q_pois[0], o_poisoned);
                    check_bit(cur, "rtc", q_rtc[0], o_rtc);
                    check_bit(cur, "flow", q_flow[0], o_flow);
                    if (pkt_flits != q_len[0]) begin
                        mismatches++;
                        $display("Mismatch %s flit count expected %0d actual %0d",
                                 cur, q_len[0], pkt_flits);
                    end
                    pkt_flits = 0;
                    void'(q_name.pop_front());
                    void'(q_err.pop_front());
                    void'(q_pois.pop_front());
                    void'(q_rtc.pop_front());
                    void'(q_flow.pop_front());
                    void'(q_len.pop_front());
                end
            end else if (o_hdr || o_tail || o_error || o_poisoned || o_rtc || o_flow) begin
                other_errs++;
                $display("Output marker or flag set while output valid is low");
            end else if (q_cyc.size() > 0 && (cyc - q_cyc[0]) > 3) begin
                other_errs++;
                $display("Input flit of %s never appeared on the output", cur);
                void'(q_data.pop_front());
                void'(q_hdr.pop_front());
                void'(q_tail.pop_front());
                void'(q_cyc.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_rx_crc_check.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rx_crc_check;

    import rx_flit_pkg::*;

    localparam int MAX_LNG = 9;
    localparam int N_TESTS = 18;

    logic              clk;
    logic              res_n;
    logic              i_valid;
    logic              i_hdr;
    logic              i_tail;
    logic [FLIT_W-1:0] i_data;
    logic              o_valid;
    logic              o_hdr;
    logic              o_tail;
    logic [FLIT_W-1:0] o_data;
    logic              o_error;
    logic              o_poisoned;
    logic              o_rtc;
    logic              o_flow;

    // ============================================================
    // Packet table
    // ============================================================
    // Corruption kind: 0 none, 1 flipped payload bit, 2 inverted CRC
    string       t_name[N_TESTS];
    logic [5:0]  t_cmd[N_TESTS];
    logic [3:0]  t_lng[N_TESTS];
    int          t_nfl[N_TESTS];
    logic [8:0]  t_tag[N_TESTS];
    logic [33:0] t_adrs[N_TESTS];
    logic [2:0]  t_rtc[N_TESTS];
    logic [2:0]  t_seq[N_TESTS];
    logic [7:0]  t_frp[N_TESTS];
    int          t_corr[N_TESTS];
    logic [3:0]  t_exp[N_TESTS];
    int          n_ent = 0;
    logic [31:0] rng_state = 32'hb06f;

    task automatic add_entry(input string name, input logic [5:0] cmd, input logic [3:0] lng,
                             input int nfl, input logic [8:0] tag, input logic [33:0] adrs,
                             input logic [2:0] rtc, input logic [2:0] seq,
                             input logic [7:0] frp, input int corr, input logic [3:0] exp);
        t_name[n_ent] = name;
        t_cmd[n_ent]  = cmd;
        t_lng[n_ent]  = lng;
        t_nfl[n_ent]  = nfl;
        t_tag[n_ent]  = tag;
        t_adrs[n_ent] = adrs;
        t_rtc[n_ent]  = rtc;
        t_seq[n_ent]  = seq;
        t_frp[n_ent]  = frp;
        t_corr[n_ent] = corr;
        t_exp[n_ent]  = exp;
        n_ent++;
    endtask

    // Expected flags packed as {error, poisoned, rtc, flow}
    task automatic fill_table();
        add_entry("good_multi",  6'h08, 4'd4,  4,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b0010);
        add_entry("good_single", 6'h30, 4'd1,  1,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b0010);
        add_entry("good_max",    6'h08, 4'd9,  9,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b0010);
        add_entry("flip_bit",    6'h08, 4'd3,  3,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 1, 4'b1010);
        add_entry("poison",      6'h08, 4'd2,  2,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 2, 4'b0110);
        add_entry("pret_ok",     6'h01, 4'd1,  1,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b0001);
        add_entry("tret_ok",     6'h02, 4'd1,  1,  9'd0, 34'd0, 3'd5, 3'd3, 8'd9, 0, 4'b0011);
        add_entry("irtry_ok",    6'h03, 4'd1,  1,  9'd0, 34'd0, 3'd0, 3'd0, 8'd7, 0, 4'b0001);
        add_entry("flow_tag",    6'h02, 4'd1,  1,  9'd5, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b1011);
        add_entry("flow_adrs",   6'h03, 4'd1,  1,  9'd0, 34'h1_0000_0000, 3'd0, 3'd0, 8'd0, 0,
                  4'b1001);
        add_entry("pret_rtc",    6'h01, 4'd1,  1,  9'd0, 34'd0, 3'd2, 3'd0, 8'd0, 0, 4'b1001);
        add_entry("pret_seq",    6'h01, 4'd1,  1,  9'd0, 34'd0, 3'd0, 3'd1, 8'd0, 0, 4'b1001);
        add_entry("pret_frp",    6'h01, 4'd1,  1,  9'd0, 34'd0, 3'd0, 3'd0, 8'h40, 0, 4'b1001);
        add_entry("tail_early",  6'h08, 4'd4,  3,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b1010);
        add_entry("tail_late",   6'h08, 4'd2,  3,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b1010);
        add_entry("lng_zero",    6'h08, 4'd0,  1,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b1010);
        add_entry("lng_over",    6'h08, 4'd10, 10, 9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 0, 4'b1010);
        add_entry("poison_pret", 6'h01, 4'd1,  1,  9'd0, 34'd0, 3'd0, 3'd0, 8'd0, 2, 4'b0101);
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    task automatic send_packet(input int idx);
        logic [FLIT_W-1:0] flits[16];
        logic [FLIT_W-1:0] f;
        logic [CRC_W-1:0]  crc;
        int                n;
        int                gap;
        n   = t_nfl[idx];
        crc = '0;
        for (int k = 0; k < n; k++) begin
            f = {next_rand(), next_rand(), next_rand(), next_rand()};
            if (k == 0) begin
                f[5:0]   = t_cmd[idx];
                f[10:7]  = t_lng[idx];
                f[23:15] = t_tag[idx];
                f[57:24] = t_adrs[idx];
            end
            if (k == n - 1) begin
                f[79:72]  = t_frp[idx];
                f[82:80]  = t_seq[idx];
                f[90:88]  = t_rtc[idx];
                f[127:96] = '0;
            end
            crc      = f_crc_flit(crc, f);
            flits[k] = f;
        end
        flits[n-1][127:96] = (t_corr[idx] == 2) ? ~crc : crc;
        // Bit 60 lies outside every checked header field
        if (t_corr[idx] == 1) begin
            flits[0][60] = ~flits[0][60];
        end
        u_chk.expect_packet(t_name[idx], t_exp[idx][3], t_exp[idx][2], t_exp[idx][1],
                            t_exp[idx][0], n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            i_valid = 1'b1;
            i_hdr   = (k == 0);
            i_tail  = (k == n - 1);
            i_data  = flits[k];
        end
        gap = int'(next_rand() % 32'd3);
        for (int g = 0; g < gap; g++) begin
            @(negedge clk);
            i_valid = 1'b0;
            i_hdr   = 1'b0;
            i_tail  = 1'b0;
        end
    endtask

    tb_clock_gen u_clk (
        .o_clk   (clk),
        .o_res_n (res_n)
    );

    rx_crc_check_top #(
        .MAX_LNG (MAX_LNG)
    ) uut (
        .clk        (clk),
        .res_n      (res_n),
        .i_valid    (i_valid),
        .i_hdr      (i_hdr),
        .i_tail     (i_tail),
        .i_data     (i_data),
        .o_valid    (o_valid),
        .o_hdr      (o_hdr),
        .o_tail     (o_tail),
        .o_data     (o_data),
        .o_error    (o_error),
        .o_poisoned (o_poisoned),
        .o_rtc      (o_rtc),
        .o_flow     (o_flow)
    );

    tb_rx_checker u_chk (
        .clk        (clk),
        .res_n      (res_n),
        .i_valid    (i_valid),
        .i_hdr      (i_hdr),
        .i_tail     (i_tail),
        .i_data     (i_data),
        .o_valid    (o_valid),
        .o_hdr      (o_hdr),
        .o_tail     (o_tail),
        .o_data     (o_data),
        .o_error    (o_error),
        .o_poisoned (o_poisoned),
        .o_rtc      (o_rtc),
        .o_flow     (o_flow)
    );

    initial begin
        int wait_cnt;
        i_valid = 1'b0;
        i_hdr   = 1'b0;
        i_tail  = 1'b0;
        i_data  = '0;
        fill_table();
        wait_cnt = 0;
        while (res_n !== 1'b1) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > 20) begin
                $display("Reset was never released");
                $display(">>> FAIL");
                $finish;
            end
        end
        for (int t = 0; t < n_ent; t++) begin
            send_packet(t);
        end
        @(negedge clk);
        i_valid = 1'b0;
        i_hdr   = 1'b0;
        i_tail  = 1'b0;
        wait_cnt = 0;
        while (!u_chk.drained() && wait_cnt <= 50) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!u_chk.drained()) begin
            $display("Output stream stalled with flits still expected");
            $display(">>> FAIL");
            $finish;
        end
        $display("Packets %0d, flits %0d, mismatches %0d, other errors %0d",
                 u_chk.pkts_seen, u_chk.flits_seen, u_chk.mismatches, u_chk.other_errs);
        if (u_chk.mismatches == 0 && u_chk.other_errs == 0 && u_chk.pkts_seen == n_ent) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/rx_flit_pkg.sv
hw/rx_crc_accum.sv
hw/rx_field_check.sv
hw/rx_flit_merge.sv
hw/rx_crc_check_top.sv
tests/tb_clock_gen.sv
tests/rx_crc_check_sva.sv
tests/tb_rx_checker.sv
tests/tb_rx_crc_check.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds with Verilator and runs the testbench, the log decides the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_rx_crc_check \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "build or simulation run ended abnormally"

touch sim.log
cat sim.log

grep -q ">>> FAIL" sim.log && exit 1 || grep -q ">>> PASS" sim.log && exit 0 || exit 1
